// File: build.f
logic/issue_pkg.sv
logic/bypass_if.sv
logic/reg_file.sv
logic/wake_up.sv
logic/operand_select.sv
logic/branch_unit.sv
logic/decode_stage.sv
logic/issue_top.sv
tests/issue_checks.sv
tests/issue_tb.sv

// File: tests/issue_tb.sv
// testbench for issue_top: plays predecode, execute, writeback and bypass, models expected issue
`timescale 1ns/1ps

module issue_tb;

	// six tests of at most about 200 cycles plus reset, with margin
	localparam int MAX_CYCLES = 2000;

	logic                             clk = 1'b0;
	logic                             reset;
	logic                             in_valid;
	issue_pkg::decoded_inst_t         in_inst;
	logic                             in_allow;
	logic                             out_valid;
	issue_pkg::issue_bundle_t         out_bundle;
	logic                             exe_allow;
	logic                             wb_we;
	logic [issue_pkg::REG_ADDR_W-1:0] wb_addr;
	logic [issue_pkg::XLEN-1:0]       wb_data;
	logic [issue_pkg::REG_ADDR_W-1:0] byp_exe_dest;
	logic                             byp_exe_w_en;
	logic                             byp_exe_data_ready;
	logic [issue_pkg::XLEN-1:0]       byp_exe_data;
	logic [issue_pkg::REG_ADDR_W-1:0] byp_mem_dest;
	logic                             byp_mem_w_en;
	logic                             byp_mem_data_ready;
	logic [issue_pkg::XLEN-1:0]       byp_mem_data;
	logic [issue_pkg::REG_ADDR_W-1:0] byp_wb_dest;
	logic                             byp_wb_w_en;
	logic                             byp_wb_data_ready;
	logic [issue_pkg::XLEN-1:0]       byp_wb_data;
	logic                             cancel;
	logic [issue_pkg::XLEN-1:0]       redirect_pc;

	// expectations handed to the checker
	logic                             exp_blocked;
	issue_pkg::issue_bundle_t         exp_bundle;
	logic [issue_pkg::XLEN-1:0]       exp_next_pc;
	logic                             exp_cancel;

	logic [issue_pkg::XLEN-1:0]       shadow [32];
	integer                           seed = 32'hff00;
	int                               cycles = 0;

	always #2 clk = ~clk;

	issue_top UUT (.*);

	issue_checks checks (.*);

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("run timed out after %0d cycles, a handshake never completed", cycles);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// reference model

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// youngest writer wins, then the shadow registers
	function automatic logic [31:0] model_reg(input logic [4:0] a);
		if (a == 5'd0)
			return 32'd0;
		if (byp_exe_w_en && byp_exe_dest == a)
			return byp_exe_data;
		if (byp_mem_w_en && byp_mem_dest == a)
			return byp_mem_data;
		if (byp_wb_w_en && byp_wb_dest == a)
			return byp_wb_data;
		return shadow[a];
	endfunction

	function automatic issue_pkg::issue_bundle_t model_bundle(input issue_pkg::decoded_inst_t i);
		issue_pkg::issue_bundle_t b;
		b.result_stage = i.result_stage;
		b.rf_w_en      = i.rf_w_en;
		b.mem_en       = i.mem_en;
		b.mem_we       = i.mem_we;
		b.rd           = i.rd;
		b.alu_op       = i.alu_op;
		b.inst_pc      = i.inst_pc;
		b.store_data   = i.mem_we ? model_reg(i.rk) : 32'd0;
		case (i.src1_sel)
			issue_pkg::SRC1_REG: b.alu_src1 = model_reg(i.rj);
			issue_pkg::SRC1_PC:  b.alu_src1 = i.inst_pc;
			default:             b.alu_src1 = 32'd0;
		endcase
		case (i.src2_sel)
			issue_pkg::SRC2_REG:  b.alu_src2 = model_reg(i.rk);
			issue_pkg::SRC2_IMM:  b.alu_src2 = i.imm;
			issue_pkg::SRC2_FOUR: b.alu_src2 = 32'd4;
			default:              b.alu_src2 = 32'd0;
		endcase
		return b;
	endfunction

	function automatic logic [31:0] model_next_pc(input issue_pkg::decoded_inst_t i);
		issue_pkg::issue_bundle_t b;
		logic                     jump;
		b = model_bundle(i);
		case (i.br_kind)
			issue_pkg::BR_BEQ:  jump = (b.alu_src1 == b.alu_src2);
			issue_pkg::BR_BNE:  jump = (b.alu_src1 != b.alu_src2);
			issue_pkg::BR_BLT:  jump = ($signed(b.alu_src1) < $signed(b.alu_src2));
			issue_pkg::BR_BGE:  jump = ($signed(b.alu_src1) >= $signed(b.alu_src2));
			issue_pkg::BR_BLTU: jump = (b.alu_src1 < b.alu_src2);
			issue_pkg::BR_BGEU: jump = (b.alu_src1 >= b.alu_src2);
			issue_pkg::BR_B, issue_pkg::BR_BL, issue_pkg::BR_JIRL: jump = 1'b1;
			default:            jump = 1'b0;
		endcase
		if (!jump)
			return i.inst_pc + issue_pkg::PC_STEP;
		if (i.br_kind == issue_pkg::BR_JIRL)
			return b.alu_src1 + i.imm;
		return i.inst_pc + i.imm;
	endfunction

	// plain register-register alu instruction, fetch guess left at zero
	function automatic issue_pkg::decoded_inst_t random_inst();
		issue_pkg::decoded_inst_t i;
		i = '0;
		i.src1_sel     = issue_pkg::SRC1_REG;
		i.src2_sel     = issue_pkg::SRC2_REG;
		i.rf_w_en      = $random(seed);
		i.result_stage = issue_pkg::result_stage_e'(rand_below(3));
		i.br_kind      = issue_pkg::BR_NONE;
		i.alu_op       = issue_pkg::alu_op_e'(rand_below(12));
		i.inst_pc      = $random(seed) & 32'hffff_fffc;
		i.imm          = $random(seed) & 32'hffff_fffc;
		i.rd           = $random(seed);
		i.rj           = $random(seed);
		i.rk           = $random(seed);
		return i;
	endfunction

	//////////////////////////////////////////////////
	// drivers, each starts and ends at a falling edge

	task write_reg(input logic [4:0] a, input logic [31:0] d);
		@(negedge clk);
		wb_we   = 1'b1;
		wb_addr = a;
		wb_data = d;
		if (a != 5'd0)
			shadow[a] = d;
		@(negedge clk);
		wb_we = 1'b0;
	endtask

	task set_bypass(input logic [4:0] e, input logic [4:0] m, input logic [4:0] w);
		{byp_exe_dest, byp_exe_w_en, byp_exe_data_ready} = {e, 2'b11};
		{byp_mem_dest, byp_mem_w_en, byp_mem_data_ready} = {m, 2'b11};
		{byp_wb_dest, byp_wb_w_en, byp_wb_data_ready}    = {w, 2'b11};
		byp_exe_data = $random(seed);
		byp_mem_data = $random(seed);
		byp_wb_data  = $random(seed);
	endtask

	task clear_bypass;
		byp_exe_w_en = 1'b0;
		byp_mem_w_en = 1'b0;
		byp_wb_w_en  = 1'b0;
	endtask

	task set_expect(input issue_pkg::decoded_inst_t i);
		exp_bundle  = model_bundle(i);
		exp_next_pc = model_next_pc(i);
		exp_cancel  = (exp_next_pc != i.pred_pc);
	endtask

	task offer(input issue_pkg::decoded_inst_t i);
		in_valid = 1'b1;
		in_inst  = i;
		do @(posedge clk); while (!in_allow);
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task wait_issue;
		do @(posedge clk); while (!(out_valid && exe_allow));
		@(negedge clk);
	endtask

	task run_one(input issue_pkg::decoded_inst_t i);
		set_expect(i);
		offer(i);
		wait_issue();
	endtask

	//////////////////////////////////////////////////
	// test sequences

	initial
	begin
		issue_pkg::decoded_inst_t i;
		issue_pkg::decoded_inst_t j;
		logic [4:0]               dests [4][3];

		reset = 1'b1;
		in_valid = 1'b0;
		in_inst = '0;
		exe_allow = 1'b1;
		{wb_we, wb_addr, wb_data} = '0;
		{byp_exe_dest, byp_exe_data, byp_mem_dest, byp_mem_data} = '0;
		{byp_wb_dest, byp_wb_data} = '0;
		{byp_exe_data_ready, byp_mem_data_ready, byp_wb_data_ready} = 3'b111;
		clear_bypass();
		{exp_blocked, exp_cancel, exp_bundle, exp_next_pc} = '0;
		repeat (16) @(negedge clk);
		reset = 1'b0;

		// register reads, r0 in the first two
		checks.start_test("reg_read");
		for (int a = 0; a < 32; a++)
			write_reg(a, $random(seed));
		for (int k = 0; k < 8; k++)
		begin
			i = random_inst();
			if (k == 0)
				i.rj = 5'd0;
			if (k == 1)
				i.rk = 5'd0;
			i.pred_pc = model_next_pc(i);
			run_one(i);
		end
		checks.end_test(8);

		// same register held in several stages
		checks.start_test("forward_priority");
		dests = '{'{5, 5, 5}, '{6, 5, 5}, '{6, 6, 5}, '{5, 6, 6}};
		for (int k = 0; k < 4; k++)
		begin
			set_bypass(dests[k][0], dests[k][1], dests[k][2]);
			i = random_inst();
			i.rj = 5'd5;
			i.rk = 5'd6;
			i.pred_pc = model_next_pc(i);
			run_one(i);
		end
		checks.end_test(4);

		// youngest writer not ready, then a store waiting on rk
		checks.start_test("hazard_stall");
		for (int k = 0; k < 2; k++)
		begin
			i = random_inst();
			clear_bypass();
			if (k == 0)
			begin
				set_bypass(7, 7, 0);
				byp_wb_w_en = 1'b0;
				byp_exe_data_ready = 1'b0;
				i.rj = 5'd7;
				i.src2_sel = issue_pkg::SRC2_IMM;
			end
			else
			begin
				set_bypass(0, 0, 9);
				{byp_exe_w_en, byp_mem_w_en, byp_wb_data_ready} = 3'b000;
				i.src1_sel = issue_pkg::SRC1_ZERO;
				i.src2_sel = issue_pkg::SRC2_IMM;
				{i.rk, i.mem_en, i.mem_we} = {5'd9, 2'b11};
			end
			i.pred_pc = model_next_pc(i);
			set_expect(i);
			offer(i);
			exp_blocked = 1'b1;
			repeat (5) @(negedge clk);
			exp_blocked = 1'b0;
			{byp_exe_data_ready, byp_wb_data_ready} = 2'b11;
			wait_issue();
		end
		clear_bypass();
		checks.end_test(2);

		// execute stalls with a second instruction waiting
		checks.start_test("back_pressure");
		i = random_inst();
		i.pred_pc = model_next_pc(i);
		j = random_inst();
		j.pred_pc = model_next_pc(j);
		exe_allow = 1'b0;
		set_expect(i);
		offer(i);
		in_valid = 1'b1;
		in_inst = j;
		repeat (6) @(negedge clk);
		exe_allow = 1'b1;
		wait_issue();
		in_valid = 1'b0;
		set_expect(j);
		wait_issue();
		// mispredicted jump held back must not cancel early
		i = random_inst();
		i.br_kind = issue_pkg::BR_B;
		i.pred_pc = model_next_pc(i) + 32'd8;
		exe_allow = 1'b0;
		set_expect(i);
		offer(i);
		repeat (4) @(negedge clk);
		exe_allow = 1'b1;
		wait_issue();
		checks.end_test(3);

		// random branches, wrong-path offer in each cancel cycle
		checks.start_test("branch_resolve");
		for (int k = 0; k < 12; k++)
		begin
			i = random_inst();
			i.br_kind = issue_pkg::br_kind_e'(rand_below(10));
			if (rand_below(2) == 0)
				i.rk = i.rj;
			i.pred_pc = model_next_pc(i);
			if (rand_below(2) == 0)
				i.pred_pc = i.pred_pc ^ 32'h40;
			set_expect(i);
			offer(i);
			if (exp_cancel)
			begin
				j = random_inst();
				j.inst_pc = ~i.inst_pc;
				in_valid = 1'b1;
				in_inst = j;
			end
			wait_issue();
			in_valid = 1'b0;
			repeat (2) @(negedge clk);
		end
		checks.end_test(12);

		// pc, immediate, link four and store data
		checks.start_test("source_select");
		for (int k = 0; k < 10; k++)
		begin
			i = random_inst();
			i.src1_sel = issue_pkg::src1_sel_e'(rand_below(3));
			i.src2_sel = issue_pkg::src2_sel_e'(rand_below(4));
			i.mem_we = $random(seed);
			i.mem_en = i.mem_we | $random(seed);
			if (i.src2_sel == issue_pkg::SRC2_FOUR)
				i.br_kind = issue_pkg::BR_BL;
			i.pred_pc = model_next_pc(i);
			run_one(i);
		end
		checks.end_test(10);

		$display("tests passed %0d, failed %0d", checks.tests_passed, checks.tests_failed);
		if (checks.tests_failed == 0)
		begin
			$display("Test completed successfully");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: tests/issue_checks.sv
// port checker for the issue stage, instantiated by the testbench; keeps error counts per test
`timescale 1ns/1ps

module issue_checks (
	input logic                             clk,
	input logic                             reset,
	input logic                             in_allow,
	input logic                             out_valid,
	input issue_pkg::issue_bundle_t         out_bundle,
	input logic                             exe_allow,
	input logic                             cancel,
	input logic [issue_pkg::XLEN-1:0]       redirect_pc,

	// expected values from the reference model
	input logic                             exp_blocked,
	input issue_pkg::issue_bundle_t         exp_bundle,
	input logic [issue_pkg::XLEN-1:0]       exp_next_pc,
	input logic                             exp_cancel
);

	string                    cur_name = "none";
	int                       test_errs = 0;
	int                       issued = 0;
	int                       tests_passed = 0;
	int                       tests_failed = 0;
	logic                     reset_q = 1'b0;
	logic                     cancel_q = 1'b0;
	logic                     held_q = 1'b0;
	issue_pkg::issue_bundle_t held_bundle;

	task automatic report_mismatch(input string what, input logic [159:0] exp_val,
			input logic [159:0] act_val);
		$display("ERR %s %s expected %h actual %h", cur_name, what, exp_val, act_val);
		test_errs++;
	endtask

	task automatic report_failure(input string msg);
		$display("%s: %s", cur_name, msg);
		test_errs++;
	endtask

	task start_test(input string name);
		cur_name = name;
		test_errs = 0;
		issued = 0;
	endtask

	task end_test(input int exp_issues);
		assert (issued == exp_issues)
		else report_failure($sformatf("%0d bundles issued for %0d accepted instructions",
			issued, exp_issues));
		if (test_errs == 0)
		begin
			tests_passed++;
			$display("%s: pass", cur_name);
		end
		else
		begin
			tests_failed++;
			$display("%s: fail, %0d errors", cur_name, test_errs);
		end
	endtask

	//////////////////////////////////////////////////
	// checks at every rising edge

	always @(posedge clk)
	begin
		if (!reset)
		begin
			if (out_valid && exe_allow)
			begin
				issued++;
				assert (out_bundle === exp_bundle)
				else report_mismatch("out_bundle", exp_bundle, out_bundle);
				assert (redirect_pc === exp_next_pc)
				else report_mismatch("redirect_pc", exp_next_pc, redirect_pc);
				assert (cancel === exp_cancel)
				else report_mismatch("cancel", exp_cancel, cancel);
			end
			assert (!cancel || (out_valid && exe_allow))
			else report_failure("cancel was raised without an issue");
			assert (!(cancel && cancel_q))
			else report_failure("cancel stayed high for more than one cycle");
			// back-pressure holds the stage closed
			if (out_valid && !exe_allow)
			begin
				assert (!in_allow && !cancel)
				else report_failure("stage accepted input or cancelled while held");
			end
			if (held_q)
			begin
				assert (out_valid === 1'b1 && out_bundle === held_bundle)
				else report_failure("held bundle changed or vanished under back-pressure");
			end
			if (exp_blocked)
			begin
				assert (!out_valid && !in_allow)
				else report_failure("instruction offered past a hazard, or input accepted");
			end
			if (reset_q)
			begin
				assert (!out_valid && in_allow && !cancel)
				else report_failure("handshake outputs wrong right after reset");
			end
		end
		held_q      <= !reset && out_valid && !exe_allow;
		held_bundle <= out_bundle;
		cancel_q    <= cancel;
		reset_q     <= reset;
	end

endmodule

// File: logic/issue_top.sv
// top level of the issue stage, plain ports for the surrounding pipeline and the testbench
`timescale 1ns/1ps

module issue_top (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             in_valid,
	input  issue_pkg::decoded_inst_t         in_inst,
	output logic                             in_allow,
	output logic                             out_valid,
	output issue_pkg::issue_bundle_t         out_bundle,
	input  logic                             exe_allow,
	input  logic                             wb_we,
	input  logic [issue_pkg::REG_ADDR_W-1:0] wb_addr,
	input  logic [issue_pkg::XLEN-1:0]       wb_data,

	// bypass from exe, mem and wb
	input  logic [issue_pkg::REG_ADDR_W-1:0] byp_exe_dest,
	input  logic                             byp_exe_w_en,
	input  logic                             byp_exe_data_ready,
	input  logic [issue_pkg::XLEN-1:0]       byp_exe_data,
	input  logic [issue_pkg::REG_ADDR_W-1:0] byp_mem_dest,
	input  logic                             byp_mem_w_en,
	input  logic                             byp_mem_data_ready,
	input  logic [issue_pkg::XLEN-1:0]       byp_mem_data,
	input  logic [issue_pkg::REG_ADDR_W-1:0] byp_wb_dest,
	input  logic                             byp_wb_w_en,
	input  logic                             byp_wb_data_ready,
	input  logic [issue_pkg::XLEN-1:0]       byp_wb_data,

	output logic                             cancel,
	output logic [issue_pkg::XLEN-1:0]       redirect_pc
);

	bypass_if byp ();

	assign byp.exe_dest       = byp_exe_dest;
	assign byp.exe_w_en       = byp_exe_w_en;
	assign byp.exe_data_ready = byp_exe_data_ready;
	assign byp.exe_data       = byp_exe_data;
	assign byp.mem_dest       = byp_mem_dest;
	assign byp.mem_w_en       = byp_mem_w_en;
	assign byp.mem_data_ready = byp_mem_data_ready;
	assign byp.mem_data       = byp_mem_data;
	assign byp.wb_dest        = byp_wb_dest;
	assign byp.wb_w_en        = byp_wb_w_en;
	assign byp.wb_data_ready  = byp_wb_data_ready;
	assign byp.wb_data        = byp_wb_data;

	decode_stage u_decode_stage (
		.clk         (clk),
		.reset       (reset),
		.in_valid    (in_valid),
		.in_inst     (in_inst),
		.in_allow    (in_allow),
		.out_valid   (out_valid),
		.out_bundle  (out_bundle),
		.exe_allow   (exe_allow),
		.wb_we       (wb_we),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data),
		.byp         (byp),
		.cancel      (cancel),
		.redirect_pc (redirect_pc)
	);

endmodule

// File: logic/decode_stage.sv
// decode-and-issue stage: holds one instruction, waits on hazards and issues a bundle to execute
`timescale 1ns/1ps

module decode_stage (
	input  logic                             clk,
	input  logic                             reset,

	// from predecode
	input  logic                             in_valid,
	input  issue_pkg::decoded_inst_t         in_inst,
	output logic                             in_allow,

	// to execute
	output logic                             out_valid,
	output issue_pkg::issue_bundle_t         out_bundle,
	input  logic                             exe_allow,

	// register write from writeback
	input  logic                             wb_we,
	input  logic [issue_pkg::REG_ADDR_W-1:0] wb_addr,
	input  logic [issue_pkg::XLEN-1:0]       wb_data,

	bypass_if.sink                           byp,

	// redirect to fetch and predecode
	output logic                             cancel,
	output logic [issue_pkg::XLEN-1:0]       redirect_pc
);

	logic                       stage_valid;
	issue_pkg::decoded_inst_t   inst_q;
	issue_pkg::src2_sel_e       wake_src2_sel;
	logic                       src1_ready;
	logic                       src2_ready;
	logic                       issue;
	logic                       mispredict;
	logic [issue_pkg::XLEN-1:0] rf_data1;
	logic [issue_pkg::XLEN-1:0] rf_data2;
	logic [issue_pkg::XLEN-1:0] alu_src1;
	logic [issue_pkg::XLEN-1:0] alu_src2;
	logic [issue_pkg::XLEN-1:0] store_data;

	//////////////////////////////////////////////////
	// handshake

	assign out_valid = stage_valid && src1_ready && src2_ready;
	assign issue     = out_valid && exe_allow;
	assign in_allow  = !stage_valid || issue;
	assign cancel    = issue && mispredict;

	// wrong-path instruction offered with cancel is dropped
	always_ff @(posedge clk)
	begin
		if (reset)
			stage_valid <= 1'b0;
		else if (in_allow)
			stage_valid <= in_valid && !cancel;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid && in_allow && !cancel)
			inst_q <= in_inst;
	end

	//////////////////////////////////////////////////
	// datapath blocks

	reg_file u_reg_file (
		.clk     (clk),
		.r_addr1 (inst_q.rj),
		.r_addr2 (inst_q.rk),
		.r_data1 (rf_data1),
		.r_data2 (rf_data2),
		.w_en    (wb_we),
		.w_addr  (wb_addr),
		.w_data  (wb_data)
	);

	// store data also reads rk, so it must wait like a register operand
	assign wake_src2_sel = inst_q.mem_we ? issue_pkg::SRC2_REG : inst_q.src2_sel;

	wake_up u_wake_up (
		.src1_sel   (inst_q.src1_sel),
		.src2_sel   (wake_src2_sel),
		.rj         (inst_q.rj),
		.rk         (inst_q.rk),
		.byp        (byp),
		.src1_ready (src1_ready),
		.src2_ready (src2_ready)
	);

	operand_select u_operand_select (
		.src1_sel   (inst_q.src1_sel),
		.src2_sel   (inst_q.src2_sel),
		.rj         (inst_q.rj),
		.rk         (inst_q.rk),
		.inst_pc    (inst_q.inst_pc),
		.imm        (inst_q.imm),
		.mem_we     (inst_q.mem_we),
		.rf_data1   (rf_data1),
		.rf_data2   (rf_data2),
		.byp        (byp),
		.alu_src1   (alu_src1),
		.alu_src2   (alu_src2),
		.store_data (store_data)
	);

	// compares run on the forwarded operands
	branch_unit u_branch_unit (
		.br_kind    (inst_q.br_kind),
		.inst_pc    (inst_q.inst_pc),
		.pred_pc    (inst_q.pred_pc),
		.imm        (inst_q.imm),
		.src1       (alu_src1),
		.src2       (alu_src2),
		.next_pc    (redirect_pc),
		.mispredict (mispredict)
	);

	//////////////////////////////////////////////////
	// issue bundle

	always_comb
	begin
		out_bundle.result_stage = inst_q.result_stage;
		out_bundle.rf_w_en      = inst_q.rf_w_en;
		out_bundle.mem_en       = inst_q.mem_en;
		out_bundle.mem_we       = inst_q.mem_we;
		out_bundle.store_data   = store_data;
		out_bundle.rd           = inst_q.rd;
		out_bundle.alu_op       = inst_q.alu_op;
		out_bundle.alu_src1     = alu_src1;
		out_bundle.alu_src2     = alu_src2;
		out_bundle.inst_pc      = inst_q.inst_pc;
	end

endmodule

// File: logic/branch_unit.sv
// branch resolution: condition, target and check against the fetch stage's predicted pc
`timescale 1ns/1ps

module branch_unit (
	input  issue_pkg::br_kind_e        br_kind,
	input  logic [issue_pkg::XLEN-1:0] inst_pc,
	input  logic [issue_pkg::XLEN-1:0] pred_pc,
	input  logic [issue_pkg::XLEN-1:0] imm,
	input  logic [issue_pkg::XLEN-1:0] src1,
	input  logic [issue_pkg::XLEN-1:0] src2,
	output logic [issue_pkg::XLEN-1:0] next_pc,
	output logic                       mispredict
);

	logic                       eq;
	logic                       lt_s;
	logic                       lt_u;
	logic                       taken;
	logic [issue_pkg::XLEN-1:0] target_base;
	logic [issue_pkg::XLEN-1:0] target;
	logic [issue_pkg::XLEN-1:0] fall_through;

	//////////////////////////////////////////////////
	// compares

	assign eq   = (src1 == src2);
	assign lt_s = ($signed(src1) < $signed(src2));
	assign lt_u = (src1 < src2);

	always_comb
	begin
		case (br_kind)
			issue_pkg::BR_BEQ:  taken = eq;
			issue_pkg::BR_BNE:  taken = !eq;
			issue_pkg::BR_BLT:  taken = lt_s;
			issue_pkg::BR_BGE:  taken = !lt_s;
			issue_pkg::BR_BLTU: taken = lt_u;
			issue_pkg::BR_BGEU: taken = !lt_u;
			// unconditional kinds
			issue_pkg::BR_B,
			issue_pkg::BR_BL,
			issue_pkg::BR_JIRL: taken = 1'b1;
			default:            taken = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////
	// target and next pc

	// jirl is register relative, the rest pc relative
	assign target_base  = (br_kind == issue_pkg::BR_JIRL) ? src1 : inst_pc;
	assign target       = target_base + imm;
	assign fall_through = inst_pc + issue_pkg::PC_STEP;

	assign next_pc = taken ? target : fall_through;

	// non-branches are checked too, a bad fetch guess redirects as well
	assign mispredict = (next_pc != pred_pc);

endmodule

// File: logic/operand_select.sv
// forwarding and source muxes producing both ALU operands and the store data at issue
`timescale 1ns/1ps

module operand_select (
	input  issue_pkg::src1_sel_e             src1_sel,
	input  issue_pkg::src2_sel_e             src2_sel,
	input  logic [issue_pkg::REG_ADDR_W-1:0] rj,
	input  logic [issue_pkg::REG_ADDR_W-1:0] rk,
	input  logic [issue_pkg::XLEN-1:0]       inst_pc,
	input  logic [issue_pkg::XLEN-1:0]       imm,
	input  logic                             mem_we,
	input  logic [issue_pkg::XLEN-1:0]       rf_data1,
	input  logic [issue_pkg::XLEN-1:0]       rf_data2,
	bypass_if.sink                           byp,
	output logic [issue_pkg::XLEN-1:0]       alu_src1,
	output logic [issue_pkg::XLEN-1:0]       alu_src2,
	output logic [issue_pkg::XLEN-1:0]       store_data
);

	// index 0 is rj, index 1 is rk
	logic [issue_pkg::REG_ADDR_W-1:0] addr    [2];
	logic [issue_pkg::XLEN-1:0]       rf_data [2];
	logic [issue_pkg::XLEN-1:0]       reg_val [2];

	assign addr[0]    = rj;
	assign addr[1]    = rk;
	assign rf_data[0] = rf_data1;
	assign rf_data[1] = rf_data2;

	//////////////////////////////////////////////////
	// register value with forwarding

	// exe before mem before wb, youngest wins
	for (genvar i = 0; i < 2; i++)
	begin : g_fwd
		always_comb
		begin
			if (addr[i] == '0)
				reg_val[i] = '0;
			else if (byp.exe_w_en && (byp.exe_dest == addr[i]))
				reg_val[i] = byp.exe_data;
			else if (byp.mem_w_en && (byp.mem_dest == addr[i]))
				reg_val[i] = byp.mem_data;
			else if (byp.wb_w_en && (byp.wb_dest == addr[i]))
				reg_val[i] = byp.wb_data;
			else
				reg_val[i] = rf_data[i];
		end
	end

	//////////////////////////////////////////////////
	// operand muxes

	always_comb
	begin
		case (src1_sel)
			issue_pkg::SRC1_REG: alu_src1 = reg_val[0];
			issue_pkg::SRC1_PC:  alu_src1 = inst_pc;
			default:             alu_src1 = '0;
		endcase
	end

	always_comb
	begin
		case (src2_sel)
			issue_pkg::SRC2_REG:  alu_src2 = reg_val[1];
			issue_pkg::SRC2_IMM:  alu_src2 = imm;
			// link value for bl
			issue_pkg::SRC2_FOUR: alu_src2 = issue_pkg::PC_STEP;
			default:              alu_src2 = '0;
		endcase
	end

	// stores take rk through the same forwarding path
	assign store_data = mem_we ? reg_val[1] : '0;

endmodule

// File: logic/wake_up.sv
// hazard check telling the issue stage whether each register source can be taken this cycle
`timescale 1ns/1ps

module wake_up (
	input  issue_pkg::src1_sel_e             src1_sel,
	input  issue_pkg::src2_sel_e             src2_sel,
	input  logic [issue_pkg::REG_ADDR_W-1:0] rj,
	input  logic [issue_pkg::REG_ADDR_W-1:0] rk,
	bypass_if.sink                           byp,
	output logic                             src1_ready,
	output logic                             src2_ready
);

	// index 0 is rj, index 1 is rk
	logic [1:0]                       reads_reg;
	logic [issue_pkg::REG_ADDR_W-1:0] addr [2];
	logic [1:0]                       ready;

	assign reads_reg[0] = (src1_sel == issue_pkg::SRC1_REG);
	assign reads_reg[1] = (src2_sel == issue_pkg::SRC2_REG);
	assign addr[0]      = rj;
	assign addr[1]      = rk;

	// youngest matching writer decides
	for (genvar i = 0; i < 2; i++)
	begin : g_src
		always_comb
		begin
			if (!reads_reg[i] || (addr[i] == '0))
			begin
				ready[i] = 1'b1;
			end
			else if (byp.exe_w_en && (byp.exe_dest == addr[i]))
			begin
				ready[i] = byp.exe_data_ready;
			end
			else if (byp.mem_w_en && (byp.mem_dest == addr[i]))
			begin
				ready[i] = byp.mem_data_ready;
			end
			else if (byp.wb_w_en && (byp.wb_dest == addr[i]))
			begin
				ready[i] = byp.wb_data_ready;
			end
			else
			begin
				// no pending writer, register file holds it
				ready[i] = 1'b1;
			end
		end
	end

	assign src1_ready = ready[0];
	assign src2_ready = ready[1];

endmodule

// File: logic/reg_file.sv
// 32-entry integer register file, two combinational reads and one write port from writeback
`timescale 1ns/1ps

module reg_file (
	input  logic                             clk,

	// read ports
	input  logic [issue_pkg::REG_ADDR_W-1:0] r_addr1,
	input  logic [issue_pkg::REG_ADDR_W-1:0] r_addr2,
	output logic [issue_pkg::XLEN-1:0]       r_data1,
	output logic [issue_pkg::XLEN-1:0]       r_data2,

	// write port, driven by writeback
	input  logic                             w_en,
	input  logic [issue_pkg::REG_ADDR_W-1:0] w_addr,
	input  logic [issue_pkg::XLEN-1:0]       w_data
);

	logic [issue_pkg::XLEN-1:0] regs [32];

	//////////////////////////////////////////////////
	// write

	// r0 is never stored
	always_ff @(posedge clk)
	begin
		if (w_en && (w_addr != '0))
		begin
			regs[w_addr] <= w_data;
		end
	end

	//////////////////////////////////////////////////
	// read

	// a same-cycle write is not visible here, the wb bypass covers it
	always_comb
	begin
		r_data1 = (r_addr1 == '0) ? '0 : regs[r_addr1];
		r_data2 = (r_addr2 == '0) ? '0 : regs[r_addr2];
	end

endmodule

// File: logic/bypass_if.sv
// bypass bus from the exe, mem and wb stages back to the issue hazard and forwarding logic
`timescale 1ns/1ps

interface bypass_if;

	// exe group, youngest writer
	logic [issue_pkg::REG_ADDR_W-1:0] exe_dest;
	logic                             exe_w_en;
	logic                             exe_data_ready;
	logic [issue_pkg::XLEN-1:0]       exe_data;

	// mem group
	logic [issue_pkg::REG_ADDR_W-1:0] mem_dest;
	logic                             mem_w_en;
	logic                             mem_data_ready;
	logic [issue_pkg::XLEN-1:0]       mem_data;

	// wb group, oldest writer
	logic [issue_pkg::REG_ADDR_W-1:0] wb_dest;
	logic                             wb_w_en;
	logic                             wb_data_ready;
	logic [issue_pkg::XLEN-1:0]       wb_data;

	modport source (
		output exe_dest, exe_w_en, exe_data_ready, exe_data,
		output mem_dest, mem_w_en, mem_data_ready, mem_data,
		output wb_dest, wb_w_en, wb_data_ready, wb_data
	);

	modport sink (
		input exe_dest, exe_w_en, exe_data_ready, exe_data,
		input mem_dest, mem_w_en, mem_data_ready, mem_data,
		input wb_dest, wb_w_en, wb_data_ready, wb_data
	);

endinterface

// File: logic/issue_pkg.sv
// shared widths, opcodes and bundle types for the issue stage; compile before all other files
package issue_pkg;

	//////////////////////////////////////////////////
	// widths and constants

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	// fall-through pc increment, also the bl link offset
	localparam logic [XLEN-1:0] PC_STEP = 32'd4;

	//////////////////////////////////////////////////
	// encodings

	// passed through to execute untouched
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
		ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_e;

	typedef enum logic [3:0] {
		BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
		BR_BLTU, BR_BGEU, BR_B, BR_BL, BR_JIRL
	} br_kind_e;

	typedef enum logic [1:0] {SRC1_ZERO, SRC1_REG, SRC1_PC} src1_sel_e;

	// four is the bl link value
	typedef enum logic [1:0] {SRC2_ZERO, SRC2_REG, SRC2_IMM, SRC2_FOUR} src2_sel_e;

	// stage where the result can first be forwarded
	typedef enum logic [1:0] {RES_EXE, RES_MEM, RES_WB} result_stage_e;

	//////////////////////////////////////////////////
	// bundles

	// from predecode into the stage register
	typedef struct packed {
		src1_sel_e                src1_sel;
		src2_sel_e                src2_sel;
		logic                     rf_w_en;
		result_stage_e            result_stage;
		logic                     mem_en;
		logic                     mem_we;
		br_kind_e                 br_kind;
		alu_op_e                  alu_op;
		logic [XLEN-1:0]          pred_pc;
		logic [XLEN-1:0]          inst_pc;
		logic [XLEN-1:0]          imm;
		logic [REG_ADDR_W-1:0]    rd;
		logic [REG_ADDR_W-1:0]    rj;
		logic [REG_ADDR_W-1:0]    rk;
	} decoded_inst_t;

	// issued to execute
	typedef struct packed {
		result_stage_e            result_stage;
		logic                     rf_w_en;
		logic                     mem_en;
		logic                     mem_we;
		logic [XLEN-1:0]          store_data;
		logic [REG_ADDR_W-1:0]    rd;
		alu_op_e                  alu_op;
		logic [XLEN-1:0]          alu_src1;
		logic [XLEN-1:0]          alu_src2;
		logic [XLEN-1:0]          inst_pc;
	} issue_bundle_t;

endpackage
